// File: led_cfg.svh
`ifndef LED_CFG_SVH
`define LED_CFG_SVH

// Panel geometry.
`define LED_DRIVERS 2
`define LED_WORDS 9
`define LED_COLUMNS 8

// Dark time between columns, in enabled cycles.
`define LED_BLANKING 72

// Function-control word shifted out after reset.
`define LED_DEFAULT_FC 48'h0001_0E7F_F3C0

`endif

// File: led_pkg.sv
`default_nettype none

`include "led_cfg.svh"

package led_pkg;

    typedef logic [$clog2(`LED_COLUMNS * `LED_DRIVERS * `LED_WORDS)-1:0] fb_addr_t;

    // One frame-buffer access.
    typedef struct packed {
        logic        valid;
        logic        write;
        fb_addr_t    addr;
        logic [47:0] data;
    } fb_req_t;

    localparam logic KIND_PIXEL = 1'b0;
    localparam logic KIND_CONFIG = 1'b1;

    typedef struct packed {
        logic        kind;
        logic [2:0]  spare;
        logic [2:0]  col;
        logic        drv;
        logic [3:0]  word;
        logic [39:0] gs;     // Grayscale.
    } host_pixel_t;

    typedef struct packed {
        logic        kind;
        logic [2:0]  spare;
        logic [47:0] fc;     // Function-control word.
    } host_config_t;

    // Host word, decoded by its kind bit.
    typedef union packed {
        host_pixel_t  pix;
        host_config_t cfg;
    } host_cmd_u;

    typedef enum logic [3:0] {
        STALL,
        SEND_TMGRST,
        PREPARE_CONFIG,
        CONFIG,
        WRTFC_TIMING,
        WAIT_FOR_SOF,
        BLANKING,
        PAUSE_SCLK,
        SHIFT_REGISTER
    } drv_state_e;

endpackage

`default_nettype wire

// File: frame_buffer.sv
`default_nettype none

`include "led_cfg.svh"

module frame_buffer import led_pkg::*; (
    input  logic        clk,
    input  fb_req_t     req,
    output logic [47:0] rdata
);

    localparam int DEPTH = `LED_COLUMNS * `LED_DRIVERS * `LED_WORDS;

    logic [47:0] mem [DEPTH];

    // One access per cycle, read data valid on the next cycle.
    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.write) begin
                mem[req.addr] <= req.data;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: fb_arbiter.sv
`default_nettype none

module fb_arbiter import led_pkg::*; (
    input  logic    clk,
    input  logic    nrst,
    input  fb_req_t host_req,
    input  fb_req_t fetch_req,
    output fb_req_t mem_req,
    output logic    fetch_grant,
    output logic    fetch_rvalid
);

    // The host always wins, the fetcher takes idle cycles.
    assign fetch_grant = fetch_req.valid && !host_req.valid;
    assign mem_req = host_req.valid ? host_req : fetch_req;

    // Marks the read data that belongs to the fetcher.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            fetch_rvalid <= 1'b0;
        end else begin
            fetch_rvalid <= fetch_grant && !fetch_req.write;
        end
    end

endmodule

`default_nettype wire

// File: host_port.sv
`default_nettype none

`include "led_cfg.svh"

module host_port import led_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        host_wr,
    input  host_cmd_u   host_word,
    output fb_req_t     host_req,
    output logic        cfg_load,
    output logic [47:0] cfg_word
);

    localparam int WORDS = `LED_WORDS;
    localparam int COL_WORDS = `LED_DRIVERS * `LED_WORDS;

    logic        req_valid;
    fb_addr_t    req_addr;
    logic [47:0] req_data;
    fb_addr_t    pixel_addr;

    // Word index above 8 spills into the next slot; the host keeps it in range.
    assign pixel_addr = fb_addr_t'(host_word.pix.col) * fb_addr_t'(COL_WORDS)
                      + fb_addr_t'(host_word.pix.drv) * fb_addr_t'(WORDS)
                      + fb_addr_t'(host_word.pix.word);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            req_valid <= 1'b0;
            cfg_load <= 1'b0;
        end else begin
            req_valid <= host_wr && host_word.pix.kind == KIND_PIXEL;
            cfg_load <= host_wr && host_word.cfg.kind == KIND_CONFIG;
        end
    end

    always_ff @(posedge clk) begin
        if (host_wr) begin
            req_addr <= pixel_addr;
            req_data <= {host_word.pix.gs, 8'h00};  // Grayscale sits in the top 40 bits.
            cfg_word <= host_word.cfg.fc;
        end
    end

    assign host_req = '{valid: req_valid, write: 1'b1, addr: req_addr, data: req_data};

endmodule

`default_nettype wire

// File: column_fetch.sv
`default_nettype none

`include "led_cfg.svh"

module column_fetch import led_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        col_start,
    input  logic [2:0]  col_index,
    output fb_req_t     fetch_req,
    input  logic        fetch_grant,
    input  logic        fetch_rvalid,
    input  logic [47:0] rdata,
    output logic [`LED_DRIVERS*`LED_WORDS*48-1:0] line_data,
    output logic        line_ready
);

    localparam int TOTAL = `LED_DRIVERS * `LED_WORDS;

    logic [4:0] req_cnt;    // TOTAL means idle.
    logic [4:0] rsp_cnt;
    fb_addr_t   base;

    assign fetch_req.valid = req_cnt != 5'(TOTAL);
    assign fetch_req.write = 1'b0;
    assign fetch_req.addr = base + fb_addr_t'(req_cnt);
    assign fetch_req.data = '0;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            req_cnt <= 5'(TOTAL);
            rsp_cnt <= '0;
            line_ready <= 1'b0;
        end else if (col_start) begin
            req_cnt <= '0;
            rsp_cnt <= '0;
            line_ready <= 1'b0;
        end else begin
            if (fetch_grant) begin
                req_cnt <= req_cnt + 1'b1;  // Hold the address until granted.
            end
            if (fetch_rvalid) begin
                rsp_cnt <= rsp_cnt + 1'b1;
                if (rsp_cnt == 5'(TOTAL - 1)) begin
                    line_ready <= 1'b1;
                end
            end
        end
    end

    // Word 0 of driver 0 lands in the top 48 bits.
    always_ff @(posedge clk) begin
        if (col_start) begin
            base <= fb_addr_t'(col_index) * fb_addr_t'(TOTAL);
        end
        if (fetch_rvalid) begin
            line_data[(TOTAL - int'(rsp_cnt)) * 48 - 1 -: 48] <= rdata;
        end
    end

endmodule

`default_nettype wire

// File: driver_controller.sv
`default_nettype none

`include "led_cfg.svh"

module driver_controller import led_pkg::*; (
    input  logic                    clk,
    input  logic                    clk_enable,
    input  logic                    nrst,
    input  logic                    sof,
    output logic                    eoc,
    input  logic                    cfg_load,
    input  logic [47:0]             cfg_word,
    output logic                    end_config,
    output logic                    col_start,
    output logic [2:0]              col_index,
    input  logic [`LED_DRIVERS*`LED_WORDS*48-1:0] line_data,
    input  logic                    line_ready,
    output logic                    driver_sclk,
    output logic                    driver_gclk,
    output logic                    driver_lat,
    output logic [`LED_DRIVERS-1:0] drivers_sin,
    output logic [`LED_COLUMNS-1:0] mux_out
);

    localparam int SEG_BITS = 48;
    localparam int LINE_BITS = `LED_WORDS * SEG_BITS;
    localparam int TMGRST_LEN = 21;
    localparam int TMGRST_LAT = 13;
    localparam int FCWRTEN_LEN = 15;
    localparam int CONFIG_LEN = 49;    // One dead SCLK, then 48 bits.
    localparam int WRTFC_LAT = 5;
    localparam int WRTFC_WAIT = 5;
    localparam int LATGS_LAT = 3;
    localparam int LINERESET_LAT = 7;
    localparam int GCLK_TAIL = 512;    // GCLK kept running after the frame.

    drv_state_e state;
    logic [9:0] state_cnt;
    logic [3:0] wrtgs_cnt;            // Segment within the column.
    logic [8:0] data_idx;             // Bit within the column.
    logic [2:0] column_cnt;
    logic       first_latgs;
    logic       cfg_pending;
    logic [47:0] cfg_buffer;
    logic [3:0] mux_cnt;              // LED_COLUMNS means all rows off.
    logic       seg_end;
    logic       last_seg;
    logic       last_col;

    assign seg_end = state_cnt == 10'(SEG_BITS - 1);
    assign last_seg = wrtgs_cnt == 4'(`LED_WORDS - 1);
    assign last_col = column_cnt == 3'(`LED_COLUMNS - 1);
    assign col_index = column_cnt;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cfg_pending <= 1'b0;
            cfg_buffer <= `LED_DEFAULT_FC;
        end else if (cfg_load) begin
            cfg_pending <= 1'b1;
            cfg_buffer <= cfg_word;
        end else if (state == PREPARE_CONFIG) begin
            cfg_pending <= 1'b0;
        end
    end

    // Main sequencer. sof is only sampled on enabled cycles.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= STALL;
            state_cnt <= '0;
            wrtgs_cnt <= '0;
            data_idx <= '0;
            column_cnt <= '0;
            first_latgs <= 1'b0;
            col_start <= 1'b0;
        end else begin
            col_start <= 1'b0;
            if (clk_enable) begin
                case (state)
                    STALL: begin
                        state_cnt <= '0;
                        state <= SEND_TMGRST;
                    end
                    SEND_TMGRST: begin
                        state_cnt <= state_cnt + 1'b1;
                        if (state_cnt == 10'(TMGRST_LEN - 1)) begin
                            state_cnt <= '0;
                            state <= PREPARE_CONFIG;
                        end
                    end
                    PREPARE_CONFIG: begin
                        state_cnt <= state_cnt + 1'b1;   // FCWRTEN.
                        if (state_cnt == 10'(FCWRTEN_LEN - 1)) begin
                            state_cnt <= '0;
                            state <= CONFIG;
                        end
                    end
                    CONFIG: begin
                        state_cnt <= state_cnt + 1'b1;
                        if (state_cnt == 10'(CONFIG_LEN - 1)) begin
                            state_cnt <= '0;
                            state <= WRTFC_TIMING;
                        end
                    end
                    WRTFC_TIMING: begin
                        state_cnt <= state_cnt + 1'b1;
                        if (state_cnt == 10'(WRTFC_WAIT)) begin
                            state_cnt <= '0;
                            state <= WAIT_FOR_SOF;
                        end
                    end
                    WAIT_FOR_SOF: begin
                        if (state_cnt <= 10'(GCLK_TAIL)) begin
                            state_cnt <= state_cnt + 1'b1;
                        end
                        if (cfg_pending) begin
                            state_cnt <= '0;
                            state <= SEND_TMGRST;
                        end else if (sof) begin
                            state_cnt <= '0;
                            column_cnt <= '0;
                            first_latgs <= 1'b0;
                            col_start <= 1'b1;
                            state <= BLANKING;
                        end
                    end
                    BLANKING: begin
                        wrtgs_cnt <= '0;
                        data_idx <= '0;
                        if (state_cnt != 10'(`LED_BLANKING - 1)) begin
                            state_cnt <= state_cnt + 1'b1;
                        end else if (line_ready) begin   // Else wait for the fetch.
                            state_cnt <= '0;
                            state <= PAUSE_SCLK;
                        end
                    end
                    PAUSE_SCLK: begin
                        state <= SHIFT_REGISTER;
                    end
                    SHIFT_REGISTER: begin
                        state_cnt <= state_cnt + 1'b1;
                        data_idx <= data_idx + 1'b1;
                        if (seg_end) begin
                            state_cnt <= '0;
                            wrtgs_cnt <= wrtgs_cnt + 1'b1;
                            state <= PAUSE_SCLK;
                            if (last_seg) begin
                                wrtgs_cnt <= '0;
                                first_latgs <= 1'b1;
                                if (last_col) begin
                                    column_cnt <= '0;
                                    state <= WAIT_FOR_SOF;
                                end else begin
                                    column_cnt <= column_cnt + 1'b1;
                                    col_start <= 1'b1;
                                    state <= BLANKING;
                                end
                            end
                        end
                    end
                    default: begin
                        state_cnt <= '0;
                        state <= STALL;
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (state)
            CONFIG:         driver_sclk = clk_enable && state_cnt != '0;
            STALL, WAIT_FOR_SOF, BLANKING, PAUSE_SCLK, WRTFC_TIMING: driver_sclk = 1'b0;
            default:        driver_sclk = clk_enable;
        endcase
    end

    // GCLK runs only once a column has been latched.
    always_comb begin
        case (state)
            SHIFT_REGISTER, PAUSE_SCLK: driver_gclk = clk_enable && first_latgs;
            BLANKING: driver_gclk = clk_enable && first_latgs && state_cnt != '0;
            WAIT_FOR_SOF: begin
                driver_gclk = clk_enable && first_latgs && state_cnt != '0
                              && state_cnt <= 10'(GCLK_TAIL);
            end
            default: driver_gclk = 1'b0;
        endcase
    end

    // LAT changes on the falling edge for hold time after SCLK.
    always_ff @(negedge clk or negedge nrst) begin
        if (!nrst) begin
            driver_lat <= 1'b0;
        end else begin
            case (state)
                SEND_TMGRST:    driver_lat <= state_cnt < 10'(TMGRST_LAT);
                PREPARE_CONFIG: driver_lat <= 1'b1;
                CONFIG:         driver_lat <= state_cnt >= 10'(CONFIG_LEN - WRTFC_LAT); // WRTFC.
                SHIFT_REGISTER: begin
                    driver_lat <= seg_end
                        || (last_seg && state_cnt >= 10'(SEG_BITS - LATGS_LAT))
                        || (last_seg && last_col && state_cnt >= 10'(SEG_BITS - LINERESET_LAT));
                end
                default:        driver_lat <= 1'b0;
            endcase
        end
    end

    // MSB first, from the config word or from each driver's line.
    always_comb begin
        drivers_sin = '0;
        case (state)
            CONFIG: begin
                if (state_cnt != '0) begin
                    drivers_sin = {`LED_DRIVERS{cfg_buffer[CONFIG_LEN - 1 - int'(state_cnt)]}};
                end
            end
            SHIFT_REGISTER: begin
                for (int d = 0; d < `LED_DRIVERS; d++) begin
                    drivers_sin[d] = line_data[(`LED_DRIVERS - d) * LINE_BITS - 1 - int'(data_idx)];
                end
            end
            default: drivers_sin = '0;
        endcase
    end

    assign eoc = clk_enable && state == SHIFT_REGISTER && last_seg && seg_end;
    assign end_config = clk_enable && state == WRTFC_TIMING && state_cnt == 10'(WRTFC_WAIT);

    // Row select.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mux_cnt <= 4'(`LED_COLUMNS);
            mux_out <= '0;
        end else begin
            if (sof) begin
                mux_cnt <= 4'(`LED_COLUMNS);
            end else if (eoc) begin
                mux_cnt <= (mux_cnt == 4'(`LED_COLUMNS)) ? '0 : mux_cnt + 1'b1;
            end
            mux_out <= '0;
            if (mux_cnt < 4'(`LED_COLUMNS)) begin
                mux_out[mux_cnt[2:0]] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: led_top.sv
`default_nettype none

`include "led_cfg.svh"

module led_top import led_pkg::*; (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    clk_enable,
    input  logic                    host_wr,
    input  host_cmd_u               host_word,
    input  logic                    sof,
    output logic                    eoc,
    output logic                    end_config,
    output logic                    driver_sclk,
    output logic                    driver_gclk,
    output logic                    driver_lat,
    output logic [`LED_DRIVERS-1:0] drivers_sin,
    output logic [`LED_COLUMNS-1:0] mux_out
);

    fb_req_t     host_req;
    fb_req_t     fetch_req;
    fb_req_t     mem_req;
    logic        fetch_grant;
    logic        fetch_rvalid;
    logic [47:0] rdata;
    logic        cfg_load;
    logic [47:0] cfg_word;
    logic        col_start;
    logic [2:0]  col_index;
    logic        line_ready;
    logic [`LED_DRIVERS*`LED_WORDS*48-1:0] line_data;

    host_port i_host (
        .clk(clk), .nrst(nrst), .host_wr(host_wr), .host_word(host_word),
        .host_req(host_req), .cfg_load(cfg_load), .cfg_word(cfg_word)
    );

    fb_arbiter i_arb (
        .clk(clk), .nrst(nrst), .host_req(host_req), .fetch_req(fetch_req),
        .mem_req(mem_req), .fetch_grant(fetch_grant), .fetch_rvalid(fetch_rvalid)
    );

    frame_buffer i_fb (
        .clk(clk), .req(mem_req), .rdata(rdata)
    );

    column_fetch i_fetch (
        .clk(clk), .nrst(nrst), .col_start(col_start), .col_index(col_index),
        .fetch_req(fetch_req), .fetch_grant(fetch_grant), .fetch_rvalid(fetch_rvalid),
        .rdata(rdata), .line_data(line_data), .line_ready(line_ready)
    );

    driver_controller i_ctrl (
        .clk(clk), .clk_enable(clk_enable), .nrst(nrst), .sof(sof), .eoc(eoc),
        .cfg_load(cfg_load), .cfg_word(cfg_word), .end_config(end_config),
        .col_start(col_start), .col_index(col_index), .line_data(line_data),
        .line_ready(line_ready), .driver_sclk(driver_sclk), .driver_gclk(driver_gclk),
        .driver_lat(driver_lat), .drivers_sin(drivers_sin), .mux_out(mux_out)
    );

endmodule

`default_nettype wire

// File: led_chk.sv
`default_nettype none

`include "led_cfg.svh"

module led_chk (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    eoc,
    input  logic                    driver_sclk,
    input  logic                    driver_gclk,
    input  logic [`LED_COLUMNS-1:0] mux_out
);

    // At most one row is driven.
    row_onehot: assert property (@(posedge clk) $onehot0(mux_out))
        else $error("mux_out selects more than one row");

    // Driver clocks stay quiet in reset.
    clocks_in_reset: assert property (@(posedge clk) !nrst |-> !driver_sclk && !driver_gclk)
        else $error("driver_sclk or driver_gclk active during reset");

    eoc_single: assert property (@(posedge clk) disable iff (!nrst) eoc |=> !eoc)
        else $error("eoc longer than one cycle");   // One pulse per column.

endmodule

`default_nettype wire

// File: tb_led_top.sv
`default_nettype none

`include "led_cfg.svh"

module tb_led_top import led_pkg::*; ();

    localparam int COL_BITS = `LED_WORDS * 48;
    localparam int FRAME_BITS = `LED_COLUMNS * COL_BITS;
    localparam int CMD_SCLK = 21 + 15;           // TMGRST and then FCWRTEN.
    localparam int CFG_SCLK = CMD_SCLK + 48;
    localparam int TOTAL_SCLK = 2 * CFG_SCLK + 2 * FRAME_BITS;
    localparam int EOC_TIMEOUT = 3000;
    localparam int CFG_TIMEOUT = 2000;

    logic                    clk;
    logic                    nrst;
    logic                    clk_enable = 1'b0;
    logic                    host_wr;
    host_cmd_u               host_word;
    logic                    sof;
    logic                    eoc;
    logic                    end_config;
    logic                    driver_sclk;
    logic                    driver_gclk;
    logic                    driver_lat;
    logic [`LED_DRIVERS-1:0] drivers_sin;
    logic [`LED_COLUMNS-1:0] mux_out;

    // Model of the frame buffer and of the configuration word.
    logic [47:0] model_fb [`LED_COLUMNS][`LED_DRIVERS][`LED_WORDS];
    logic [47:0] model_fc;
    logic [31:0] en_rng = 32'h675a;
    logic [31:0] data_rng = 32'h675a;
    logic        force_en;
    logic        cfg_expected;      // A new config word follows the current frame.
    logic        in_frame;
    int          end_cfg_cnt = 0;
    int          err_cnt = 0;
    int          timeout_cnt = 0;
    int          bit_cnt;
    int          pos;
    int          dark_cnt;
    int          cfg_round;

    led_top i_dut (
        .clk(clk), .nrst(nrst), .clk_enable(clk_enable), .host_wr(host_wr),
        .host_word(host_word), .sof(sof), .eoc(eoc), .end_config(end_config),
        .driver_sclk(driver_sclk), .driver_gclk(driver_gclk), .driver_lat(driver_lat),
        .drivers_sin(drivers_sin), .mux_out(mux_out)
    );

    bind led_top led_chk i_chk (
        .clk(clk), .nrst(nrst), .eoc(eoc), .driver_sclk(driver_sclk),
        .driver_gclk(driver_gclk), .mux_out(mux_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word 0 goes out first and each word MSB first.
    function automatic logic expected_bit(input int drv, input int col, input int bitpos);
        logic [47:0] word;
        word = model_fb[col][drv][bitpos / 48];
        return word[47 - bitpos % 48];
    endfunction

    function automatic logic expected_lat(input int col, input int bitpos);
        int seg;
        int sb;
        seg = bitpos / 48;
        sb = bitpos % 48;
        if (seg == `LED_WORDS - 1 && col == `LED_COLUMNS - 1) begin
            return sb >= 41;    // Line reset of 7 SCLK.
        end else if (seg == `LED_WORDS - 1) begin
            return sb >= 45;    // LATGS of 3 SCLK.
        end
        return sb == 47;        // WRTGS.
    endfunction

    task automatic report_mismatch(input string test, input int where,
                                   input logic [47:0] exp, input logic [47:0] act);
        err_cnt++;
        $display("** Error %s at SCLK %0d: expected %0h, actual %0h", test, where, exp, act);
    endtask

    // Three enabled cycles out of four on average.
    always @(posedge clk) begin
        en_rng = xorshift32(en_rng);
        clk_enable <= (en_rng[1:0] != 2'b00) || force_en;
    end

    always @(posedge clk) begin
        if (end_config) begin
            end_cfg_cnt <= end_cfg_cnt + 1;
        end
    end

    // Walks the SCLK stream through the config sequence and then the frames.
    always @(posedge clk) begin : compare
        int col;
        int b;
        logic [`LED_DRIVERS-1:0] exp_sin;
        logic [`LED_COLUMNS-1:0] exp_mux;
        if (!nrst) begin
            in_frame = 1'b0;
            pos = 0;
            bit_cnt = 0;
            dark_cnt = 0;
            cfg_round = 0;
            cfg_expected = 1'b0;
        end else begin
            if (driver_sclk && !in_frame) begin
                bit_cnt++;
                assert (driver_gclk === 1'b0)
                    else report_mismatch("gclk", pos, 1'b0, driver_gclk);
                if (pos >= CMD_SCLK) begin
                    b = pos - CMD_SCLK;
                    exp_sin = {`LED_DRIVERS{model_fc[47 - b]}};
                    assert (drivers_sin === exp_sin)
                        else report_mismatch(cfg_round == 0 ? "boot_config" : "reconfig",
                                             pos, exp_sin, drivers_sin);
                    assert (driver_lat === (b >= 43))   // WRTFC.
                        else report_mismatch("config_latch", pos, b >= 43, driver_lat);
                end
                pos++;
                if (pos == CFG_SCLK) begin
                    pos = 0;
                    in_frame = 1'b1;
                    cfg_round++;
                end
            end else if (driver_sclk) begin
                bit_cnt++;
                col = pos / COL_BITS;
                b = pos % COL_BITS;
                if (b == 0) begin
                    exp_mux = '0;
                    if (col > 0) begin
                        exp_mux[col - 1] = 1'b1;
                    end
                    assert (mux_out === exp_mux)
                        else report_mismatch("row_select", pos, exp_mux, mux_out);
                    if (col > 0) begin
                        assert (dark_cnt > `LED_BLANKING)   // Blanking plus the pause.
                            else report_mismatch("blanking", pos, `LED_BLANKING + 1, dark_cnt);
                    end
                end
                for (int d = 0; d < `LED_DRIVERS; d++) begin
                    exp_sin[d] = expected_bit(d, col, b);
                end
                assert (drivers_sin === exp_sin)
                    else report_mismatch("frame_data", pos, exp_sin, drivers_sin);
                assert (driver_lat === expected_lat(col, b))
                    else report_mismatch("latch", pos, expected_lat(col, b), driver_lat);
                assert (driver_gclk === (col > 0))   // GCLK starts after the first LATGS.
                    else report_mismatch("gclk", pos, col > 0, driver_gclk);
                pos++;
                if (pos == FRAME_BITS) begin
                    pos = 0;
                    if (cfg_expected) begin
                        in_frame = 1'b0;
                        cfg_expected = 1'b0;
                    end
                end
            end
            if (eoc) begin
                dark_cnt = 0;
            end else if (clk_enable && !driver_sclk) begin
                dark_cnt++;
            end
        end
    end

    task automatic write_pixel(input int col, input int drv, input int word);
        host_cmd_u   cmd;
        logic [39:0] gs;
        data_rng = xorshift32(data_rng);
        gs[39:32] = data_rng[7:0];
        data_rng = xorshift32(data_rng);
        gs[31:0] = data_rng;
        cmd = '0;
        cmd.pix.kind = KIND_PIXEL;
        cmd.pix.col = 3'(col);
        cmd.pix.drv = 1'(drv);
        cmd.pix.word = 4'(word);
        cmd.pix.gs = gs;
        model_fb[col][drv][word] = {gs, 8'h00};
        host_wr <= 1'b1;
        host_word <= cmd;
        @(posedge clk);
        host_wr <= 1'b0;
        @(posedge clk);     // Idle cycle between writes.
    endtask

    task automatic write_random_pixel(input int col);
        data_rng = xorshift32(data_rng);
        write_pixel(col, int'(data_rng[4]), int'(data_rng[31:8] % `LED_WORDS));
    endtask

    task automatic load_config();
        host_cmd_u cmd;
        data_rng = xorshift32(data_rng);
        cmd = '0;
        cmd.cfg.kind = KIND_CONFIG;
        cmd.cfg.fc[47:32] = data_rng[15:0];
        data_rng = xorshift32(data_rng);
        cmd.cfg.fc[31:0] = data_rng;
        model_fc = cmd.cfg.fc;
        cfg_expected = 1'b1;
        host_wr <= 1'b1;
        host_word <= cmd;
        @(posedge clk);
        host_wr <= 1'b0;
        @(posedge clk);
    endtask

    // sof is only seen on an enabled cycle.
    task automatic pulse_sof();
        force_en <= 1'b1;
        @(posedge clk);
        sof <= 1'b1;
        @(posedge clk);
        sof <= 1'b0;
        force_en <= 1'b0;
    endtask

    task automatic wait_for_eoc(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < EOC_TIMEOUT && !ok; i++) begin
            @(posedge clk);
            ok = eoc;
        end
        if (!ok) begin
            timeout_cnt++;
            $display("Timeout: the DUT did not finish a column");
        end
    endtask

    task automatic wait_for_end_config(input int count, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < CFG_TIMEOUT && !ok; i++) begin
            @(posedge clk);
            ok = end_cfg_cnt >= count;
        end
        if (!ok) begin
            timeout_cnt++;
            $display("Timeout: the DUT did not finish its configuration sequence");
        end
    endtask

    task automatic run_sequence();
        bit ok;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        // Every frame-buffer word gets a known value.
        for (int c = 0; c < `LED_COLUMNS; c++) begin
            for (int d = 0; d < `LED_DRIVERS; d++) begin
                for (int w = 0; w < `LED_WORDS; w++) begin
                    write_pixel(c, d, w);
                end
            end
        end
        wait_for_end_config(1, ok);
        if (!ok) begin
            return;
        end
        pulse_sof();
        for (int c = 0; c < `LED_COLUMNS; c++) begin
            wait_for_eoc(ok);
            if (!ok) begin
                return;
            end
            // Column c + 1 is being fetched and c + 2 is not yet.
            if (c + 2 < `LED_COLUMNS - 1) begin
                repeat (3) write_random_pixel(c + 2);
            end
            if (c == 3) begin
                load_config();
            end
        end
        wait_for_end_config(2, ok);
        if (!ok) begin
            return;
        end
        pulse_sof();
        for (int c = 0; c < `LED_COLUMNS; c++) begin
            wait_for_eoc(ok);
            if (!ok) begin
                return;
            end
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        nrst = 1'b0;
        host_wr = 1'b0;
        host_word = '0;
        sof = 1'b0;
        force_en = 1'b0;
        model_fc = `LED_DEFAULT_FC;
        run_sequence();
        assert (bit_cnt == TOTAL_SCLK)
            else report_mismatch("sclk_count", bit_cnt, TOTAL_SCLK, bit_cnt);
        $display("Errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
led_pkg.sv
frame_buffer.sv
fb_arbiter.sv
host_port.sv
column_fetch.sv
driver_controller.sv
led_top.sv
led_chk.sv
tb_led_top.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_led_top -f all.f -o sim_led &&
    ./obj_dir/sim_led 2>&1 | tee sim.log
grep -q "PASS: all tests" sim.log 2>/dev/null && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
